// ==== rtl/kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

    typedef logic [7:0] scan_code_t;
    typedef logic [7:0] ascii_t;

    typedef struct packed {
        logic [7:0] count;      // FIFO occupancy
        logic [4:0] spare;
        logic       frame_err;  // Sticky receiver error
        logic       overflow;   // Sticky FIFO overflow
        logic       not_empty;
    } kbd_status_t;

    localparam scan_code_t SC_BREAK  = 8'hF0;
    localparam scan_code_t SC_EXTEND = 8'hE0;
    localparam scan_code_t SC_LSHIFT = 8'h12;
    localparam scan_code_t SC_RSHIFT = 8'h59;

endpackage

`default_nettype wire

// ==== rtl/scan_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface scan_if;
    import kbd_pkg::*;

    scan_code_t code;
    logic       code_valid;  // One-cycle strobes that never coincide
    logic       parity_err;
    logic       frame_err;

    modport rx (output code, output code_valid, output parity_err, output frame_err);
    modport ctrl (input code, input code_valid, input parity_err, input frame_err);

endinterface

`default_nettype wire

// ==== rtl/ps2_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
    input  logic system_clk,
    input  logic rst_n,
    input  logic ps2_clk,
    input  logic ps2_data,
    scan_if.rx   scan
);
    import kbd_pkg::*;

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic [3:0] bit_cnt;
    logic [9:0] shift_reg;
    scan_code_t frame_byte;
    logic       start_ok;
    logic       stop_ok;
    logic       parity_ok;
    logic       last_bit;
    logic       frame_end;
    logic       frame_ok;

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;  // Lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall   = clk_prev & ~clk_sync[1];
    assign last_bit   = (bit_cnt == 4'd10);
    assign frame_end  = clk_fall && last_bit;
    assign frame_byte = shift_reg[8:1];
    assign start_ok   = ~shift_reg[0];
    assign stop_ok    = data_sync[1];
    assign frame_ok   = start_ok && stop_ok;
    assign parity_ok  = ^shift_reg[9:1];  // Odd over data plus parity

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt         <= 4'd0;
            scan.code_valid <= 1'b0;
            scan.parity_err <= 1'b0;
            scan.frame_err  <= 1'b0;
        end else begin
            scan.code_valid <= frame_end && frame_ok && parity_ok;
            scan.parity_err <= frame_end && frame_ok && !parity_ok;
            scan.frame_err  <= frame_end && !frame_ok;
            if (clk_fall) begin
                if (last_bit) begin
                    bit_cnt <= 4'd0;  // Back to idle
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Start bit ends up in bit 0 after ten shifts
    always_ff @(posedge system_clk) begin
        if (clk_fall && !last_bit) begin
            shift_reg <= {data_sync[1], shift_reg[9:1]};
        end
        if (clk_fall && last_bit) begin
            scan.code <= frame_byte;
        end
    end

    a_one_strobe: assert property (@(posedge system_clk) disable iff (!rst_n)
        $onehot0({scan.code_valid, scan.parity_err, scan.frame_err}));

endmodule

`default_nettype wire

// ==== rtl/scan_to_ascii.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_to_ascii (
    input  kbd_pkg::scan_code_t code,
    input  logic                shift,
    output kbd_pkg::ascii_t     ascii
);
    import kbd_pkg::*;

    ascii_t base;
    logic   is_letter;

    always_comb begin
        is_letter = 1'b1;
        case (code)
            8'h1C: base = "a";
            8'h32: base = "b";
            8'h21: base = "c";
            8'h23: base = "d";
            8'h24: base = "e";
            8'h2B: base = "f";
            8'h34: base = "g";
            8'h33: base = "h";
            8'h43: base = "i";
            8'h3B: base = "j";
            8'h42: base = "k";
            8'h4B: base = "l";
            8'h3A: base = "m";
            8'h31: base = "n";
            8'h44: base = "o";
            8'h4D: base = "p";
            8'h15: base = "q";
            8'h2D: base = "r";
            8'h1B: base = "s";
            8'h2C: base = "t";
            8'h3C: base = "u";
            8'h2A: base = "v";
            8'h1D: base = "w";
            8'h22: base = "x";
            8'h35: base = "y";
            8'h1A: base = "z";
            default: begin
                is_letter = 1'b0;
                case (code)
                    8'h45: base = "0";
                    8'h16: base = "1";
                    8'h1E: base = "2";
                    8'h26: base = "3";
                    8'h25: base = "4";
                    8'h2E: base = "5";
                    8'h36: base = "6";
                    8'h3D: base = "7";
                    8'h3E: base = "8";
                    8'h46: base = "9";
                    8'h29: base = 8'h20;  // Space
                    8'h5A: base = 8'h0D;  // Enter
                    default: base = "?";
                endcase
            end
        endcase
    end

    // Upper case sits 0x20 below lower case
    assign ascii = (shift && is_letter) ? base - 8'h20 : base;

endmodule

`default_nettype wire

// ==== rtl/kbd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_ctrl (
    input  logic            system_clk,
    input  logic            rst_n,
    scan_if.ctrl            scan,
    output logic            push,
    output kbd_pkg::ascii_t push_char
);
    import kbd_pkg::*;

    typedef enum logic [1:0] {
        ST_NORMAL,
        ST_BREAK,
        ST_EXTEND
    } ctrl_state_t;

    ctrl_state_t state;
    logic        shift_held;
    logic        is_shift;
    ascii_t      ascii;

    scan_to_ascii u_scan_to_ascii (
        .code  (scan.code),
        .shift (shift_held),
        .ascii (ascii)
    );

    assign is_shift = (scan.code == SC_LSHIFT) || (scan.code == SC_RSHIFT);

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_NORMAL;
            shift_held <= 1'b0;
            push       <= 1'b0;
        end else begin
            push <= 1'b0;
            if (scan.parity_err || scan.frame_err) begin
                state <= ST_NORMAL;  // Resync after a bad frame
            end else if (scan.code_valid) begin
                if (scan.code == SC_EXTEND) begin
                    state <= ST_EXTEND;
                end else if (scan.code == SC_BREAK) begin
                    if (state != ST_EXTEND) begin
                        state <= ST_BREAK;  // Extended break stays ignored
                    end
                end else begin
                    state <= ST_NORMAL;
                    case (state)
                        ST_NORMAL: begin
                            if (is_shift) begin
                                shift_held <= 1'b1;
                            end else begin
                                push <= 1'b1;
                            end
                        end
                        ST_BREAK: begin
                            if (is_shift) begin
                                shift_held <= 1'b0;
                            end
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge system_clk) begin
        if (scan.code_valid) begin
            push_char <= ascii;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/char_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module char_fifo #(
    parameter int unsigned FIFO_DEPTH = 16
) (
    input  logic                        system_clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  kbd_pkg::ascii_t             push_char,
    input  logic                        pop,
    output kbd_pkg::ascii_t             head,
    output logic                        empty,
    output logic [$clog2(FIFO_DEPTH):0] count,
    output logic                        overflow
);
    import kbd_pkg::*;

    localparam int unsigned AW = $clog2(FIFO_DEPTH);

    ascii_t        mem [FIFO_DEPTH];
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full     = (count == (AW + 1)'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign overflow = push && full;  // Character dropped
    assign head     = mem[rd_ptr];

    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at power-of-two depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge system_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_char;
        end
    end

    a_no_empty_pop: assert property (@(posedge system_clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/kbd_mmio.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_mmio #(
    parameter int unsigned FIFO_DEPTH = 16,
    parameter logic [13:0] DATA_ADDR  = 14'h2500,
    parameter logic [13:0] STAT_ADDR  = 14'h2501
) (
    input  logic                        system_clk,
    input  logic                        rst_n,
    input  logic [13:0]                 address,
    input  logic                        read,
    output logic [63:0]                 data,
    input  kbd_pkg::ascii_t             head,
    input  logic                        empty,
    input  logic [$clog2(FIFO_DEPTH):0] count,
    input  logic                        overflow,
    input  logic                        parity_err,
    input  logic                        frame_err,
    output logic                        pop
);
    import kbd_pkg::*;

    logic        data_sel;
    logic        stat_sel;
    logic        ovf_sticky;
    logic        err_sticky;
    kbd_status_t status;

    assign data_sel = read && (address == DATA_ADDR);
    assign stat_sel = read && (address == STAT_ADDR);
    assign pop      = data_sel && !empty;

    always_comb begin
        status           = '0;
        status.count     = 8'(count);
        status.frame_err = err_sticky;
        status.overflow  = ovf_sticky;
        status.not_empty = !empty;
    end

    always_comb begin
        if (data_sel) begin
            data = {56'd0, empty ? 8'h00 : head};
        end else if (stat_sel) begin
            data = {48'd0, status};
        end else begin
            data = 64'd0;  // No match reads as zero
        end
    end

    // New events take priority over the clear on a status read
    always_ff @(posedge system_clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_sticky <= 1'b0;
            err_sticky <= 1'b0;
        end else begin
            if (overflow) begin
                ovf_sticky <= 1'b1;
            end else if (stat_sel) begin
                ovf_sticky <= 1'b0;
            end
            if (parity_err || frame_err) begin
                err_sticky <= 1'b1;
            end else if (stat_sel) begin
                err_sticky <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/kbd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_top #(
    parameter int unsigned FIFO_DEPTH = 16,
    parameter logic [13:0] DATA_ADDR  = 14'h2500,
    parameter logic [13:0] STAT_ADDR  = 14'h2501
) (
    input  logic        system_clk,
    input  logic        rst_n,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    input  logic [13:0] address,
    input  logic        read,
    output logic [63:0] data
);
    import kbd_pkg::*;

    logic                        push;
    ascii_t                      push_char;
    logic                        pop;
    ascii_t                      head;
    logic                        empty;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic                        overflow;

    scan_if scan_bus ();

    ps2_rx u_ps2_rx (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan       (scan_bus)
    );

    kbd_ctrl u_kbd_ctrl (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .scan       (scan_bus),
        .push       (push),
        .push_char  (push_char)
    );

    char_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_char_fifo (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_char  (push_char),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .count      (count),
        .overflow   (overflow)
    );

    kbd_mmio #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .DATA_ADDR  (DATA_ADDR),
        .STAT_ADDR  (STAT_ADDR)
    ) u_kbd_mmio (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .address    (address),
        .read       (read),
        .data       (data),
        .head       (head),
        .empty      (empty),
        .count      (count),
        .overflow   (overflow),
        .parity_err (scan_bus.parity_err),
        .frame_err  (scan_bus.frame_err),
        .pop        (pop)
    );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // Release away from the edge
    end

endmodule

`default_nettype wire

// ==== test/tb_kbd.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kbd;
    import kbd_pkg::*;

    localparam int unsigned FIFO_DEPTH = 16;
    localparam logic [13:0] DATA_ADDR  = 14'h2500;
    localparam logic [13:0] STAT_ADDR  = 14'h2501;
    localparam int PS2_HALF     = 20;  // System clocks per PS/2 half period
    localparam int TOTAL_FRAMES = 300;
    localparam int WATCHDOG_NS  = TOTAL_FRAMES * 11 * 40 * 8 + 200_000;

    // Scan codes for a..z and 0..9
    localparam scan_code_t LETTER_CODES [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    localparam scan_code_t DIGIT_CODES [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};

    logic        system_clk;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic [13:0] address;
    logic        read;
    logic [63:0] data;

    ascii_t      exp_q [$];  // Characters the FIFO should hold
    ascii_t      exp_char;
    kbd_status_t exp_stat;
    logic        m_shift;
    logic        m_break;
    logic        m_extend;
    logic        exp_err;
    logic        exp_ovf;
    int          err_cnt;
    int          test_err_start;
    int          tests_run;
    int          tests_ok;
    int          frames;

    tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clk_gen (
        .clk   (system_clk),
        .rst_n (rst_n)
    );

    kbd_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .DATA_ADDR  (DATA_ADDR),
        .STAT_ADDR  (STAT_ADDR)
    ) u_kbd_top (
        .system_clk (system_clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .address    (address),
        .read       (read),
        .data       (data)
    );

    function automatic ascii_t ref_ascii(scan_code_t code, logic shift);
        for (int i = 0; i < 26; i++) begin
            if (code == LETTER_CODES[i]) begin
                return (shift ? 8'h41 : 8'h61) + 8'(i);
            end
        end
        for (int i = 0; i < 10; i++) begin
            if (code == DIGIT_CODES[i]) begin
                return 8'h30 + 8'(i);  // Shift has no effect on digits
            end
        end
        if (code == 8'h29) begin
            return 8'h20;
        end
        if (code == 8'h5A) begin
            return 8'h0D;
        end
        return 8'h3F;
    endfunction

    task automatic model_push(ascii_t c);
        if (exp_q.size() >= FIFO_DEPTH) begin
            exp_ovf = 1'b1;
        end else begin
            exp_q.push_back(c);
        end
    endtask

    task automatic model_code(scan_code_t code);
        logic is_shift;
        is_shift = (code == SC_LSHIFT) || (code == SC_RSHIFT);
        if (code == SC_EXTEND) begin
            m_extend = 1'b1;
        end else if (code == SC_BREAK) begin
            if (!m_extend) begin
                m_break = 1'b1;
            end
        end else begin
            if (!m_extend && !m_break) begin
                if (is_shift) begin
                    m_shift = 1'b1;
                end else begin
                    model_push(ref_ascii(code, m_shift));
                end
            end else if (m_break && !m_extend && is_shift) begin
                m_shift = 1'b0;
            end
            m_break  = 1'b0;
            m_extend = 1'b0;
        end
    endtask

    task automatic wait_clks(int n);
        repeat (n) @(posedge system_clk);
        #1;
    endtask

    // Device drives data while the clock is high and the host samples on the fall
    task automatic send_frame(scan_code_t code, bit bad_parity, bit bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            wait_clks(1);
            ps2_data = bits[i];
            wait_clks(PS2_HALF);
            ps2_clk = 1'b0;
            wait_clks(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        wait_clks(PS2_HALF);  // Idle gap covers receiver and FIFO latency
        frames++;
    endtask

    task automatic send_key(scan_code_t code);
        send_frame(code, 1'b0, 1'b0);
        model_code(code);
    endtask

    task automatic tap_key(scan_code_t code);
        send_key(code);
        send_key(SC_BREAK);
        send_key(code);
    endtask

    task automatic send_bad(scan_code_t code, bit bad_parity, bit bad_stop);
        send_frame(code, bad_parity, bad_stop);
        exp_err  = 1'b1;
        m_break  = 1'b0;
        m_extend = 1'b0;
    endtask

    task automatic bus_read(logic [13:0] addr);
        @(posedge system_clk);
        #1;
        address = addr;
        read    = 1'b1;
        @(posedge system_clk);
        #1;
        read    = 1'b0;
        address = '0;
    endtask

    task automatic drain();
        int n;
        n = exp_q.size();
        repeat (n) bus_read(DATA_ADDR);
    endtask

    task automatic check_char(string name, ascii_t got, ascii_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_status(kbd_status_t got, kbd_status_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] status: got 0x%04h expected 0x%04h", got, exp);
        end
    endtask

    task automatic check_word(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%016h expected 0x%016h", name, got, exp);
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (err_cnt == test_err_start) begin
            tests_ok++;
            $display("test %0d %-24s ok", tests_run, name);
        end else begin
            $display("test %0d %-24s failed, %0d errors", tests_run, name,
                     err_cnt - test_err_start);
        end
        test_err_start = err_cnt;
    endtask

    // Read data is stable at the falling edge of a read cycle
    always @(negedge system_clk) begin
        if (rst_n && read) begin
            if (address == DATA_ADDR) begin
                if (exp_q.size() > 0) begin
                    exp_char = exp_q.pop_front();
                end else begin
                    exp_char = 8'h00;  // Empty FIFO reads zero
                end
                check_char("data[7:0]", data[7:0], exp_char);
                check_word("data", {data[63:8], 8'h00}, 64'd0);
            end else if (address == STAT_ADDR) begin
                exp_stat           = '0;
                exp_stat.count     = 8'(exp_q.size());
                exp_stat.frame_err = exp_err;
                exp_stat.overflow  = exp_ovf;
                exp_stat.not_empty = (exp_q.size() != 0);
                check_status(data[15:0], exp_stat);
                check_word("data", {data[63:16], 16'h0000}, 64'd0);
                exp_err = 1'b0;  // Read clears the sticky flags
                exp_ovf = 1'b0;
            end else begin
                check_word("data", data, 64'd0);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        int r;
        int idx;
        scan_code_t sc;
        void'($urandom(32'h56093aac));
        ps2_clk        = 1'b1;
        ps2_data       = 1'b1;
        address        = '0;
        read           = 1'b0;
        m_shift        = 1'b0;
        m_break        = 1'b0;
        m_extend       = 1'b0;
        exp_err        = 1'b0;
        exp_ovf        = 1'b0;
        err_cnt        = 0;
        test_err_start = 0;
        tests_run      = 0;
        tests_ok       = 0;
        frames         = 0;
        wait (rst_n === 1'b1);
        wait_clks(5);

        for (int i = 0; i < 36; i++) begin
            tap_key(i < 26 ? LETTER_CODES[i] : DIGIT_CODES[i - 26]);
            drain();
        end
        bus_read(STAT_ADDR);
        finish_test("letters and digits");

        for (int i = 0; i < 40; i++) begin
            r = $urandom_range(9, 0);
            if (r < 2) begin
                sc = (r == 0) ? SC_LSHIFT : SC_RSHIFT;
                if (m_shift) begin
                    send_key(SC_BREAK);
                end
                send_key(sc);
            end else begin
                idx = $urandom_range(35, 0);
                tap_key(idx < 26 ? LETTER_CODES[idx] : DIGIT_CODES[idx - 26]);
                drain();
            end
        end
        if (m_shift) begin
            send_key(SC_BREAK);
            send_key(SC_LSHIFT);
        end
        tap_key(8'h29);
        tap_key(8'h5A);
        tap_key(8'h05);  // F1 has no table entry
        drain();
        bus_read(STAT_ADDR);
        finish_test("shift and specials");

        send_key(SC_EXTEND);
        send_key(8'h1C);
        tap_key(8'h1C);
        send_key(SC_EXTEND);
        send_key(SC_BREAK);
        send_key(8'h1C);
        bus_read(STAT_ADDR);
        drain();
        finish_test("extended prefix");

        send_bad(8'h1C, 1'b1, 1'b0);
        bus_read(STAT_ADDR);
        bus_read(STAT_ADDR);
        send_bad(8'h32, 1'b0, 1'b1);
        bus_read(STAT_ADDR);
        bus_read(STAT_ADDR);
        tap_key(8'h21);
        drain();
        finish_test("frame errors");

        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            idx = $urandom_range(25, 0);
            send_key(LETTER_CODES[idx]);
        end
        bus_read(STAT_ADDR);
        drain();
        bus_read(DATA_ADDR);
        bus_read(STAT_ADDR);
        finish_test("fifo overflow");

        tap_key(8'h15);
        bus_read(STAT_ADDR);
        bus_read(14'h2502);
        bus_read(14'h0000);
        bus_read(14'h3FFF);
        bus_read(STAT_ADDR);
        drain();
        finish_test("unmapped address");

        $display("%0d tests, %0d ok, %0d failed checks, %0d frames",
                 tests_run, tests_ok, err_cnt, frames);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/kbd_pkg.sv
rtl/scan_if.sv
rtl/ps2_rx.sv
rtl/scan_to_ascii.sv
rtl/kbd_ctrl.sv
rtl/char_fifo.sv
rtl/kbd_mmio.sv
rtl/kbd_top.sv
test/tb_clk_gen.sv
test/tb_kbd.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_kbd -f filelist.f \
    -Mdir obj_dir -o tb_kbd_sim

./obj_dir/tb_kbd_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
